/* tb/apb_vectors.txt */
# op addr wdata strb exp_rdata exp_err hold, all hex except hold
# op 1 is a write, 0 a read; hold is extra cycles of psel after pready
0 01C 00000000 0 00000000 0 0
0 000 00000000 0 00000000 0 0
0 004 00000000 0 00000000 0 0
0 008 00000000 0 00000000 0 0
0 00C 00000000 0 00000000 0 0
0 010 00000000 0 00000000 0 0
0 014 00000000 0 00000000 0 0
0 018 00000000 0 00000000 0 0
1 000 12345678 F 00000000 0 0
0 000 00000000 0 12345678 0 3
1 004 A5A5A5A5 F 00000000 0 0
1 004 11223344 5 00000000 0 0
0 004 00000000 0 A522A544 0 0
1 018 DEADBEEF A 00000000 0 0
0 018 00000000 0 DE00BE00 0 2
0 01C 00000000 0 0000000F 0 0
1 020 CAFEF00D F 00000000 1 1
0 020 00000000 0 00000000 1 0
0 7FC 00000000 0 00000000 1 0
1 01C FFFFFFFF F 00000000 0 4
0 01C 00000000 0 00000014 0 2
0 000 00000000 0 12345678 0 0
0 01C 00000000 0 00000016 0 0

/* vlog.f */
source/apb_pkg.sv
source/apb_register_slice.sv
source/apb_transfer_fsm.sv
source/apb_wait_timer.sv
source/apb_reg_bank.sv
source/apb_completer_top.sv
tb/apb_completer_properties.sv
tb/apb_completer_tb.sv

/* Makefile */
# Verilator build and run of the APB completer testbench

TOP := apb_completer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "ALL CHECKS PASSED" run.log

clean:
	rm -rf obj_dir run.log

/* tb/apb_completer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_completer_tb;

	// Cycles allowed between penable and pready
	localparam int READY_TIMEOUT = 64;

	logic upstream;
	logic reset;
	logic psel;
	logic penable;
	apb_pkg::addr_t paddr;
	logic pwrite;
	apb_pkg::data_t pwdata;
	apb_pkg::strb_t pstrb;
	logic pready;
	apb_pkg::data_t prdata;
	logic pslverr;

	// Idle gap generator
	int seed = 89;

	////////////////////////////////////////
	// DUT

	apb_completer_top #(
		.DOWN_REG(1),
		.UP_REG(1),
		.WAIT_CYCLES(2),
		.REG_COUNT(8)
	) DUT (
		.upstream(upstream),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr)
	);

	// 40 ns clock
	initial begin
		upstream = 1'b0;
		forever #20 upstream = ~upstream;
	end

	////////////////////////////////////////
	// Helpers

	task automatic check_equal(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR %0t: %s, got 0x%08h, expected 0x%08h", $time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// One APB transfer, entered and left on a falling edge
	task automatic run_transfer(input logic write, input apb_pkg::addr_t addr,
			input apb_pkg::data_t wdata, input apb_pkg::strb_t strb, input int hold,
			output apb_pkg::data_t rdata, output logic err);
		int cycles;
		cycles = 0;
		// Setup phase
		psel = 1'b1;
		penable = 1'b0;
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		pstrb = strb;
		@(negedge upstream);
		// Access phase
		penable = 1'b1;
		@(negedge upstream);
		while (!pready) begin
			if (cycles >= READY_TIMEOUT) begin
				$display("Timeout: no pready for address 0x%03h after %0d cycles", addr, cycles);
				$display("CHECKS FAILED");
				$fatal(1, "pready timeout");
			end
			cycles++;
			@(negedge upstream);
		end
		// Response steady until the completing edge
		rdata = prdata;
		err = pslverr;
		@(negedge upstream);
		penable = 1'b0;
		// Stale select, must not start a second transfer
		for (int i = 0; i < hold; i++) begin
			@(negedge upstream);
			check_equal("pready while select held", pready, 1'b0);
		end
		psel = 1'b0;
	endtask

	// At least one cycle with psel low
	task automatic idle_gap();
		int gap;
		gap = 1 + ($random(seed) & 3);
		repeat (gap) @(negedge upstream);
	endtask

	////////////////////////////////////////
	// Vector replay

	initial begin
		int fd;
		int n;
		int vec_count;
		string line;
		logic [3:0] op;
		apb_pkg::addr_t addr;
		apb_pkg::data_t wdata;
		apb_pkg::strb_t strb;
		apb_pkg::data_t exp_rdata;
		logic exp_err;
		int hold;
		apb_pkg::data_t rdata;
		logic err;

		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		pstrb = '0;
		vec_count = 0;

		repeat (16) @(negedge upstream);
		reset = 1'b0;
		@(negedge upstream);

		// Quiet outputs out of reset
		check_equal("pready after reset", pready, 1'b0);
		check_equal("pslverr after reset", pslverr, 1'b0);
		check_equal("prdata after reset", prdata, 32'h0);

		fd = $fopen("tb/apb_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tb/apb_vectors.txt");
			$display("CHECKS FAILED");
			$fatal(1, "missing vector file");
		end

		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Skip comment and blank lines
			if (n > 0 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %d",
					op, addr, wdata, strb, exp_rdata, exp_err, hold);
				if (n == 7) begin
					run_transfer(op != 4'h0, addr, wdata, strb, hold, rdata, err);
					vec_count++;
					check_equal($sformatf("pslverr, vector %0d addr 0x%03h", vec_count, addr),
						err, exp_err);
					// Data only checked on reads
					if (op == 4'h0) begin
						check_equal($sformatf("prdata, vector %0d addr 0x%03h", vec_count, addr),
							rdata, exp_rdata);
					end
					idle_gap();
				end else if (n > 0) begin
					$display("Malformed line in the vector file: %s", line);
					$display("CHECKS FAILED");
					$fatal(1, "bad vector line");
				end
			end
		end
		$fclose(fd);

		if (vec_count == 0) begin
			$display("No vectors were read from the vector file");
			$display("CHECKS FAILED");
			$fatal(1, "empty vector file");
		end else begin
			$display("Replayed %0d vectors", vec_count);
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/apb_completer_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_completer_properties (
	input logic upstream,
	input logic reset,

	// Requester side of the top level
	input logic psel,
	input logic penable,
	input apb_pkg::addr_t paddr,
	input logic pwrite,
	input logic pready,

	// Internal end-of-transfer strobe
	input logic complete
);

	// Completion already seen under the current upstream select
	logic served;

	always_ff @(posedge upstream) begin
		if (reset) begin
			served <= 1'b0;
		end else if (!psel) begin
			served <= 1'b0;
		end else if (complete) begin
			served <= 1'b1;
		end
	end

	////////////////////////////////////////
	// APB handshake

	// Answer only inside an access phase
	a_ready_in_access: assert property (@(posedge upstream) disable iff (reset)
		pready |-> (psel && penable))
		else $error("pready high outside an access phase");

	// Request fields frozen while the transfer is open
	a_fields_stable: assert property (@(posedge upstream) disable iff (reset)
		(psel && !pready) |=> (!psel || ($stable(paddr) && $stable(pwrite))))
		else $error("paddr or pwrite changed before completion");

	////////////////////////////////////////
	// Completer internals

	// One commit per upstream select
	a_complete_pulse: assert property (@(posedge upstream) disable iff (reset)
		complete |-> !served)
		else $error("second complete within one upstream select");

endmodule

// Attached to the completer top level
bind apb_completer_top apb_completer_properties u_properties (
	.upstream(upstream),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.paddr(paddr),
	.pwrite(pwrite),
	.pready(pready),
	.complete(complete)
);

`default_nettype wire

/* source/apb_completer_top.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_completer_top #(
	parameter int unsigned DOWN_REG = 1,
	parameter int unsigned UP_REG = 1,
	parameter int unsigned WAIT_CYCLES = 2,
	parameter int unsigned REG_COUNT = 8
) (
	input logic upstream,
	input logic reset,

	// APB from the requester
	input logic psel,
	input logic penable,
	input apb_pkg::addr_t paddr,
	input logic pwrite,
	input apb_pkg::data_t pwdata,
	input apb_pkg::strb_t pstrb,
	output logic pready,
	output apb_pkg::data_t prdata,
	output logic pslverr
);

	// Completer side of the slice
	logic dn_psel;
	logic dn_penable;
	apb_pkg::addr_t dn_paddr;
	logic dn_pwrite;
	apb_pkg::data_t dn_pwdata;
	apb_pkg::strb_t dn_pstrb;
	logic dn_pready;
	apb_pkg::data_t dn_prdata;
	logic dn_pslverr;

	// Control between state machine, timer and bank
	logic load;
	logic expired;
	logic complete;

	////////////////////////////////////////
	// Retiming slice

	apb_register_slice #(
		.DOWN_REG(DOWN_REG),
		.UP_REG(UP_REG)
	) u_slice (
		.upstream(upstream),
		.reset(reset),
		.up_psel(psel),
		.up_penable(penable),
		.up_paddr(paddr),
		.up_pwrite(pwrite),
		.up_pwdata(pwdata),
		.up_pstrb(pstrb),
		.up_pready(pready),
		.up_prdata(prdata),
		.up_pslverr(pslverr),
		.dn_psel(dn_psel),
		.dn_penable(dn_penable),
		.dn_paddr(dn_paddr),
		.dn_pwrite(dn_pwrite),
		.dn_pwdata(dn_pwdata),
		.dn_pstrb(dn_pstrb),
		.dn_pready(dn_pready),
		.dn_prdata(dn_prdata),
		.dn_pslverr(dn_pslverr)
	);

	////////////////////////////////////////
	// Completer

	apb_transfer_fsm u_fsm (
		.upstream(upstream),
		.reset(reset),
		.psel(dn_psel),
		.penable(dn_penable),
		.expired(expired),
		.load(load),
		.pready(dn_pready),
		.complete(complete)
	);

	apb_wait_timer #(
		.WAIT_CYCLES(WAIT_CYCLES)
	) u_timer (
		.upstream(upstream),
		.reset(reset),
		.load(load),
		.expired(expired)
	);

	apb_reg_bank #(
		.REG_COUNT(REG_COUNT)
	) u_bank (
		.upstream(upstream),
		.reset(reset),
		.psel(dn_psel),
		.paddr(dn_paddr),
		.pwrite(dn_pwrite),
		.pwdata(dn_pwdata),
		.pstrb(dn_pstrb),
		.complete(complete),
		.prdata(dn_prdata),
		.pslverr(dn_pslverr)
	);

endmodule

`default_nettype wire

/* source/apb_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_reg_bank #(
	parameter int unsigned REG_COUNT = 8
) (
	input logic upstream,
	input logic reset,

	// Request fields from the slice
	input logic psel,
	input apb_pkg::addr_t paddr,
	input logic pwrite,
	input apb_pkg::data_t pwdata,
	input apb_pkg::strb_t pstrb,

	// Last cycle of a transfer
	input logic complete,

	// Response
	output apb_pkg::data_t prdata,
	output logic pslverr
);

	// Index into the general registers
	localparam int unsigned IDX_BITS = $clog2(REG_COUNT);

	// Counter sits on the top word
	localparam apb_pkg::word_t COUNT_WORD = apb_pkg::word_t'(REG_COUNT - 1);

	apb_pkg::word_t word;
	logic [IDX_BITS-1:0] idx;
	logic in_range;
	logic is_counter;
	logic commit;

	apb_pkg::data_t regs [REG_COUNT-1];
	apb_pkg::data_t xfer_count;
	apb_pkg::data_t rd_word;

	////////////////////////////////////////
	// Address decode

	assign word = paddr[apb_pkg::ADDR_BITS-1:apb_pkg::WORD_LSB];
	assign idx = word[IDX_BITS-1:0];
	assign in_range = (word <= COUNT_WORD);
	assign is_counter = (word == COUNT_WORD);

	// Counter writes drop silently
	assign commit = complete && psel && pwrite && in_range && !is_counter;

	////////////////////////////////////////
	// Storage

	// General registers, byte lanes under pstrb
	always_ff @(posedge upstream) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT - 1; i++) begin
				regs[i] <= '0;
			end
		end else if (commit) begin
			for (int b = 0; b < apb_pkg::DATA_BYTES; b++) begin
				if (pstrb[b]) begin
					regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
				end
			end
		end
	end

	// Every finished transfer counts, errors too
	always_ff @(posedge upstream) begin
		if (reset) begin
			xfer_count <= '0;
		end else if (complete) begin
			xfer_count <= xfer_count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Response

	always_comb begin
		rd_word = '0;
		if (is_counter) begin
			rd_word = xfer_count;
		end else if (in_range) begin
			rd_word = regs[idx];
		end
	end

	// Only reads drive data, out of range reads give zero
	assign prdata = (psel && !pwrite) ? rd_word : '0;
	assign pslverr = psel && !in_range;

endmodule

`default_nettype wire

/* source/apb_wait_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_wait_timer #(
	parameter int unsigned WAIT_CYCLES = 2
) (
	input logic upstream,
	input logic reset,

	// Restart from WAIT_CYCLES
	input logic load,

	// Count has run out
	output logic expired
);

	// Wait states still to go
	apb_pkg::wait_t count;

	always_ff @(posedge upstream) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= apb_pkg::wait_t'(WAIT_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// A pending load hides the old zero count
	assign expired = (count == '0) && !load;

endmodule

`default_nettype wire

/* source/apb_transfer_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_transfer_fsm (
	input logic upstream,
	input logic reset,

	// Request handshake from the slice
	input logic psel,
	input logic penable,

	// Wait timer
	input logic expired,
	output logic load,

	// Response
	output logic pready,
	output logic complete
);

	apb_pkg::ctl_state_t state;
	apb_pkg::ctl_state_t state_next;

	// Access phase seen while idle
	logic start;

	assign start = (state == apb_pkg::idle) && psel && penable;

	////////////////////////////////////////
	// Next state

	always_comb begin
		state_next = state;
		case (state)
			// Setup phase alone does nothing
			apb_pkg::idle: begin
				if (start) begin
					state_next = apb_pkg::access;
				end
			end

			// Zero wait states skip straight to the answer
			apb_pkg::access: begin
				if (expired) begin
					state_next = apb_pkg::respond;
				end else begin
					state_next = apb_pkg::wait_done;
				end
			end

			apb_pkg::wait_done: begin
				if (expired) begin
					state_next = apb_pkg::respond;
				end
			end

			// One cycle of pready, then back
			default: begin
				state_next = apb_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge upstream) begin
		if (reset) begin
			state <= apb_pkg::idle;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////
	// Outputs

	// Load goes out on the edge into access, so counting starts with the access cycle
	assign load = start;

	// Transfer ends in the respond cycle
	assign pready = (state == apb_pkg::respond);
	assign complete = (state == apb_pkg::respond);

endmodule

`default_nettype wire

/* source/apb_register_slice.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_register_slice #(
	parameter int unsigned DOWN_REG = 1,
	parameter int unsigned UP_REG = 1
) (
	input logic upstream,
	input logic reset,

	// Requester side
	input logic up_psel,
	input logic up_penable,
	input apb_pkg::addr_t up_paddr,
	input logic up_pwrite,
	input apb_pkg::data_t up_pwdata,
	input apb_pkg::strb_t up_pstrb,
	output logic up_pready,
	output apb_pkg::data_t up_prdata,
	output logic up_pslverr,

	// Completer side
	output logic dn_psel,
	output logic dn_penable,
	output apb_pkg::addr_t dn_paddr,
	output logic dn_pwrite,
	output apb_pkg::data_t dn_pwdata,
	output apb_pkg::strb_t dn_pstrb,
	input logic dn_pready,
	input apb_pkg::data_t dn_prdata,
	input logic dn_pslverr
);

	////////////////////////////////////////
	// Completion tracking

	// Set once the completer has answered, held until the requester drops psel
	logic done;

	always_ff @(posedge upstream) begin
		if (reset) begin
			done <= 1'b0;
		end else if (!up_psel) begin
			done <= 1'b0;
		end else if (dn_pready) begin
			done <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Requester to completer

	if (DOWN_REG != 0) begin : g_down_reg
		// Answer seen now, or already seen earlier
		logic block;

		assign block = done || dn_pready;

		// Select and enable, never carried past a completion
		always_ff @(posedge upstream) begin
			if (reset) begin
				dn_psel <= 1'b0;
				dn_penable <= 1'b0;
			end else begin
				dn_psel <= up_psel && !block;
				dn_penable <= up_penable && !block;
			end
		end

		// Request fields, one cycle behind the requester
		always_ff @(posedge upstream) begin
			dn_paddr <= up_paddr;
			dn_pwrite <= up_pwrite;
			dn_pwdata <= up_pwdata;
			dn_pstrb <= up_pstrb;
		end
	end else begin : g_down_comb
		// Stale select after completion is masked here
		assign dn_psel = up_psel && !done;
		assign dn_penable = up_penable && !done;
		assign dn_paddr = up_paddr;
		assign dn_pwrite = up_pwrite;
		assign dn_pwdata = up_pwdata;
		assign dn_pstrb = up_pstrb;
	end

	////////////////////////////////////////
	// Completer to requester

	if (UP_REG != 0) begin : g_up_reg
		always_ff @(posedge upstream) begin
			if (reset) begin
				up_pready <= 1'b0;
				up_prdata <= '0;
				up_pslverr <= 1'b0;
			end else begin
				up_pready <= dn_pready;
				up_prdata <= dn_prdata;
				up_pslverr <= dn_pslverr;
			end
		end
	end else begin : g_up_comb
		assign up_pready = dn_pready;
		assign up_prdata = dn_prdata;
		assign up_pslverr = dn_pslverr;
	end

endmodule

`default_nettype wire

/* source/apb_pkg.sv */
`default_nettype none

package apb_pkg;

	////////////////////////////////////////
	// Bus widths

	// Byte address reaching the completer
	localparam int unsigned ADDR_BITS = 12;

	// One data bus word
	localparam int unsigned DATA_BITS = 32;
	localparam int unsigned DATA_BYTES = DATA_BITS / 8;

	// Low address bits that select a byte inside a word
	localparam int unsigned WORD_LSB = $clog2(DATA_BYTES);

	// Wait-state count, enough for 0 to 15
	localparam int unsigned WAIT_BITS = 4;

	////////////////////////////////////////
	// Vector types

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [DATA_BITS-1:0] data_t;
	typedef logic [DATA_BYTES-1:0] strb_t;
	typedef logic [WAIT_BITS-1:0] wait_t;

	// Word address, byte address with the lane bits dropped
	typedef logic [ADDR_BITS-WORD_LSB-1:0] word_t;

	////////////////////////////////////////
	// Transfer control states

	typedef enum logic [1:0] {
		idle,
		access,
		wait_done,
		respond
	} ctl_state_t;

endpackage

`default_nettype wire
